//--- tap_pkg.sv
package tap_pkg;

    // ====================
    // probe space
    // ====================

    parameter int num_probes = 128;                 // probe signals in the tapped word.
    parameter int sel_w      = $clog2(num_probes);  // width of one probe index.

    // ====================
    // requesters
    // ====================

    // the owner also picks the tree context that serves the request.
    typedef enum logic {
        owner_trig = 1'b0,
        owner_cap  = 1'b1
    } owner_e;

    // ====================
    // request and response
    // ====================

    typedef struct packed {
        logic             req;      // request level, held until granted.
        logic [sel_w-1:0] sel;      // probe index to read.
    } tap_req_t;

    typedef struct packed {
        logic   valid;              // one cycle pulse, one cycle after the grant.
        owner_e owner;              // requester that owns this response.
        logic   bit_val;            // probe value at the requested index.
    } tap_rsp_t;

endpackage

//--- bit_select_tree.sv
module bit_select_tree (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [tap_pkg::num_probes-1:0] probes,
    input  logic [tap_pkg::sel_w-1:0]      sel,
    output logic                           bit_out
);

    localparam int n_leaves = tap_pkg::num_probes / 2;

    logic [tap_pkg::num_probes-1:0] leaf_q;         // registered probe pairs.
    // node[l][i] is node i of tree level l; level 0 holds the leaf mux outputs.
    logic [tap_pkg::sel_w-1:0][n_leaves-1:0] node;

    // ====================
    // registered leaf pairs
    // ====================

    for (genvar i = 0; i < n_leaves; i++)
    begin : g_leaf
        always_ff @(posedge clk)
        begin
            if (!rst_n)
            begin
                leaf_q[2*i]   <= 1'b0;
                leaf_q[2*i+1] <= 1'b0;
            end
            else
            begin
                leaf_q[2*i]   <= probes[2*i];
                leaf_q[2*i+1] <= probes[2*i+1];
            end
        end

        // sel bit 0 is registered upstream at the same edge as the pair.
        assign node[0][i] = sel[0] ? leaf_q[2*i+1] : leaf_q[2*i];
    end

    // ====================
    // combinational 2:1 tree
    // ====================

    for (genvar l = 1; l < tap_pkg::sel_w; l++)
    begin : g_level
        for (genvar i = 0; i < n_leaves; i++)
        begin : g_node
            if (i < (n_leaves >> l))
            begin : g_mux
                assign node[l][i] = sel[l] ? node[l-1][2*i+1] : node[l-1][2*i];
            end
            else
            begin : g_unused
                assign node[l][i] = 1'b0;   // slot above the width of this level.
            end
        end
    end

    assign bit_out = node[tap_pkg::sel_w-1][0];

endmodule

//--- dual_context_select.sv
module dual_context_select (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [tap_pkg::num_probes-1:0] probes,
    input  logic [tap_pkg::sel_w-1:0]      probe_sel,
    input  tap_pkg::owner_e                ctx,
    input  logic                           load,
    output logic                           bit_out
);

    logic [1:0][tap_pkg::num_probes-1:0] held_probes;   // last loaded probe word per context.
    logic [1:0][tap_pkg::sel_w-1:0]      held_sel;      // last loaded index per context.
    logic [1:0]                          tree_out;
    tap_pkg::owner_e                     ctx_q;         // context of the last load.

    // ====================
    // held inputs
    // ====================

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            held_probes[ctx] <= probes;
            held_sel[ctx]    <= probe_sel;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ctx_q <= tap_pkg::owner_trig;
        else if (load)
            ctx_q <= ctx;
    end

    // ====================
    // one tree per context
    // ====================

    for (genvar c = 0; c < 2; c++)
    begin : g_ctx
        logic [tap_pkg::num_probes-1:0] tree_in;

        // the active context sees live probes, the idle one its frozen copy.
        assign tree_in = (load && ctx == tap_pkg::owner_e'(c)) ? probes : held_probes[c];

        bit_select_tree u_tree (
            .clk     (clk),
            .rst_n   (rst_n),
            .probes  (tree_in),
            .sel     (held_sel[c]),
            .bit_out (tree_out[c])
        );
    end

    assign bit_out = tree_out[ctx_q];

endmodule

//--- tap_arbiter.sv
module tap_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  tap_pkg::tap_req_t         trig_req,
    input  tap_pkg::tap_req_t         cap_req,
    output logic                      trig_gnt,
    output logic                      cap_gnt,
    output logic [tap_pkg::sel_w-1:0] probe_sel,
    output tap_pkg::owner_e           ctx,
    output logic                      load,
    input  logic                      bit_in,
    output tap_pkg::tap_rsp_t         rsp
);

    tap_pkg::owner_e last_owner;    // owner of the most recent grant.
    logic            rsp_valid_q;
    tap_pkg::owner_e rsp_owner_q;

    // ====================
    // round robin grant
    // ====================

    // under contention the requester not granted last wins.
    assign trig_gnt = trig_req.req && (!cap_req.req || last_owner == tap_pkg::owner_cap);
    assign cap_gnt  = cap_req.req && (!trig_req.req || last_owner == tap_pkg::owner_trig);

    assign load      = trig_gnt || cap_gnt;
    assign ctx       = cap_gnt ? tap_pkg::owner_cap : tap_pkg::owner_trig;
    assign probe_sel = cap_gnt ? cap_req.sel : trig_req.sel;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            last_owner <= tap_pkg::owner_cap;   // so the trigger wins the first tie.
        else if (load)
            last_owner <= ctx;
    end

    // ====================
    // response
    // ====================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rsp_valid_q <= 1'b0;
            rsp_owner_q <= tap_pkg::owner_trig;
        end
        else
        begin
            rsp_valid_q <= load;
            rsp_owner_q <= ctx;
        end
    end

    assign rsp = '{valid: rsp_valid_q, owner: rsp_owner_q, bit_val: bit_in};

endmodule

//--- trigger_unit.sv
module trigger_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      arm,
    input  logic [tap_pkg::sel_w-1:0] trig_sel,
    input  logic                      trig_level,
    input  logic                      gnt,
    input  tap_pkg::tap_rsp_t         rsp,
    output tap_pkg::tap_req_t         req,
    output logic                      triggered
);

    logic in_flight;    // a granted read is waiting for its response.
    logic own_rsp;

    assign own_rsp = rsp.valid && rsp.owner == tap_pkg::owner_trig;

    // ====================
    // request
    // ====================

    assign req.req = arm && !in_flight;     // poll while armed, one read at a time.
    assign req.sel = trig_sel;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            in_flight <= 1'b0;
        else if (gnt)
            in_flight <= 1'b1;
        else if (own_rsp)
            in_flight <= 1'b0;
    end

    // ====================
    // sticky level match
    // ====================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            triggered <= 1'b0;
        end
        else if (!arm)
        begin
            triggered <= 1'b0;              // disarming clears the trigger.
        end
        else if (own_rsp && rsp.bit_val == trig_level)
        begin
            triggered <= 1'b1;
        end
    end

endmodule

//--- capture_unit.sv
module capture_unit #(
    parameter int CAP_DEPTH = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic [tap_pkg::sel_w-1:0] base,
    input  logic                      gnt,
    input  tap_pkg::tap_rsp_t         rsp,
    output tap_pkg::tap_req_t         req,
    output logic                      busy,
    output logic                      done,
    output logic [CAP_DEPTH-1:0]      cap_data
);

    localparam int cnt_w = (CAP_DEPTH > 1) ? $clog2(CAP_DEPTH) : 1;

    logic [tap_pkg::sel_w-1:0] idx;         // next probe index to read.
    logic [cnt_w-1:0]          count;       // responses stored so far.
    logic                      in_flight;
    logic                      own_rsp;
    logic                      last_rsp;

    assign own_rsp  = rsp.valid && rsp.owner == tap_pkg::owner_cap;
    assign last_rsp = own_rsp && busy && count == cnt_w'(CAP_DEPTH - 1);

    // ====================
    // request
    // ====================

    assign req.req = busy && !in_flight;
    assign req.sel = idx;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            in_flight <= 1'b0;
        else if (gnt)
            in_flight <= 1'b1;
        else if (own_rsp)
            in_flight <= 1'b0;
    end

    // the index wraps at num_probes with the width of sel.
    always_ff @(posedge clk)
    begin
        if (start && !busy)
            idx <= base;
        else if (gnt)
            idx <= idx + 1'b1;
    end

    // ====================
    // control and capture word
    // ====================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy     <= 1'b0;
            done     <= 1'b0;
            count    <= '0;
            cap_data <= '0;
        end
        else
        begin
            done <= last_rsp;               // one cycle pulse after the last response.
            if (start && !busy)
            begin
                busy     <= 1'b1;
                count    <= '0;
                cap_data <= '0;
            end
            else if (own_rsp && busy)
            begin
                cap_data[count] <= rsp.bit_val;
                count           <= count + 1'b1;
                if (last_rsp)
                    busy <= 1'b0;           // busy falls as done rises.
            end
        end
    end

endmodule

//--- signal_tap_top.sv
module signal_tap_top #(
    parameter int CAP_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [tap_pkg::num_probes-1:0] probes,
    input  logic                           arm,
    input  logic                           trig_level,
    input  logic [tap_pkg::sel_w-1:0]      trig_sel,
    input  logic                           start,
    input  logic [tap_pkg::sel_w-1:0]      base,
    output logic                           triggered,
    output logic                           busy,
    output logic                           done,
    output logic [CAP_DEPTH-1:0]           cap_data
);

    tap_pkg::tap_req_t         trig_req;
    tap_pkg::tap_req_t         cap_req;
    logic                      trig_gnt;
    logic                      cap_gnt;
    logic [tap_pkg::sel_w-1:0] probe_sel;
    tap_pkg::owner_e           ctx;
    logic                      load;
    logic                      sel_bit;
    tap_pkg::tap_rsp_t         rsp;         // broadcast to both clients.

    // ====================
    // shared select path
    // ====================

    tap_arbiter u_tap_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .trig_req  (trig_req),
        .cap_req   (cap_req),
        .trig_gnt  (trig_gnt),
        .cap_gnt   (cap_gnt),
        .probe_sel (probe_sel),
        .ctx       (ctx),
        .load      (load),
        .bit_in    (sel_bit),
        .rsp       (rsp)
    );

    dual_context_select u_dual_context_select (
        .clk       (clk),
        .rst_n     (rst_n),
        .probes    (probes),
        .probe_sel (probe_sel),
        .ctx       (ctx),
        .load      (load),
        .bit_out   (sel_bit)
    );

    // ====================
    // clients
    // ====================

    trigger_unit u_trigger_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .arm        (arm),
        .trig_sel   (trig_sel),
        .trig_level (trig_level),
        .gnt        (trig_gnt),
        .rsp        (rsp),
        .req        (trig_req),
        .triggered  (triggered)
    );

    capture_unit #(
        .CAP_DEPTH (CAP_DEPTH)
    ) u_capture_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .base     (base),
        .gnt      (cap_gnt),
        .rsp      (rsp),
        .req      (cap_req),
        .busy     (busy),
        .done     (done),
        .cap_data (cap_data)
    );

endmodule

//--- tb_clk_gen.sv
module tb_clk_gen (
    output logic clk
);

    localparam int half_period = 20;    // full period of 40 time units.

    initial
    begin
        clk = 1'b0;
        forever
            #half_period clk = ~clk;
    end

endmodule

//--- signal_tap_chk.sv
module signal_tap_chk (
    input logic              clk,
    input logic              rst_n,
    input tap_pkg::tap_req_t trig_req,
    input tap_pkg::tap_req_t cap_req,
    input logic              trig_gnt,
    input logic              cap_gnt,
    input tap_pkg::tap_rsp_t rsp
);

    tap_pkg::owner_e last_gnt;      // owner of the most recent grant seen here.
    logic            gnt_seen;      // at least one grant since reset.

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            last_gnt <= tap_pkg::owner_trig;
            gnt_seen <= 1'b0;
        end
        else if (trig_gnt || cap_gnt)
        begin
            last_gnt <= trig_gnt ? tap_pkg::owner_trig : tap_pkg::owner_cap;
            gnt_seen <= 1'b1;
        end
    end

    // ====================
    // grants
    // ====================

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(trig_gnt && cap_gnt))
        else $error("both grants high in one cycle");

    a_trig_gnt_req: assert property (@(posedge clk) disable iff (!rst_n)
        trig_gnt |-> trig_req.req)
        else $error("trigger granted without a request");

    a_cap_gnt_req: assert property (@(posedge clk) disable iff (!rst_n)
        cap_gnt |-> cap_req.req)
        else $error("capture granted without a request");

    // the requester that was not granted last wins a tie.
    a_round_robin: assert property (@(posedge clk) disable iff (!rst_n)
        (gnt_seen && trig_req.req && cap_req.req) |->
            ((last_gnt == tap_pkg::owner_trig) ? cap_gnt : trig_gnt))
        else $error("tie not resolved round robin");

    // ====================
    // responses
    // ====================

    a_trig_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        trig_gnt |=> (rsp.valid && rsp.owner == tap_pkg::owner_trig))
        else $error("no trigger response one cycle after its grant");

    a_cap_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        cap_gnt |=> (rsp.valid && rsp.owner == tap_pkg::owner_cap))
        else $error("no capture response one cycle after its grant");

    a_no_extra_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        !(trig_gnt || cap_gnt) |=> !rsp.valid)
        else $error("response without a grant in the cycle before");

endmodule

bind tap_arbiter signal_tap_chk u_signal_tap_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .trig_req (trig_req),
    .cap_req  (cap_req),
    .trig_gnt (trig_gnt),
    .cap_gnt  (cap_gnt),
    .rsp      (rsp)
);

//--- tb_signal_tap.sv
module tb_signal_tap;

    localparam int cap_depth   = 16;
    localparam int n_cap       = 12;    // plain captures.
    localparam int n_restart   = 3;     // captures with a second start while busy.
    localparam int n_hit       = 6;
    localparam int n_miss      = 4;
    localparam int n_both      = 6;     // captures with the trigger armed alongside.
    localparam int miss_cycles = 50;
    // restarts and misses run about two operations long.
    localparam int n_ops          = n_cap + 2 * n_restart + n_hit + 2 * n_miss + n_both;
    localparam int timeout_cycles = n_ops * (2 * cap_depth + 10) + 100;

    logic                           clk;
    logic                           rst_n;
    logic [tap_pkg::num_probes-1:0] probes;
    logic                           arm;
    logic                           trig_level;
    logic [tap_pkg::sel_w-1:0]      trig_sel;
    logic                           start;
    logic [tap_pkg::sel_w-1:0]      base;
    logic                           triggered;
    logic                           busy;
    logic                           done;
    logic [cap_depth-1:0]           cap_data;
    int                             seed;

    tb_clk_gen u_tb_clk_gen (
        .clk (clk)
    );

    signal_tap_top #(
        .CAP_DEPTH (cap_depth)
    ) u_signal_tap_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .probes     (probes),
        .arm        (arm),
        .trig_level (trig_level),
        .trig_sel   (trig_sel),
        .start      (start),
        .base       (base),
        .triggered  (triggered),
        .busy       (busy),
        .done       (done),
        .cap_data   (cap_data)
    );

    // ====================
    // helpers and model
    // ====================

    task automatic stop_on_error(input string msg);
        $display("ERR t=%0t %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [tap_pkg::sel_w-1:0] next_index();
        int r;
        r = $random(seed);
        return r[tap_pkg::sel_w-1:0];
    endfunction

    function automatic logic next_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    // capture bit i is probe (base + i) modulo the probe count.
    function automatic logic [cap_depth-1:0] expected_capture(
        input logic [tap_pkg::num_probes-1:0] word,
        input logic [tap_pkg::sel_w-1:0]      start_idx
    );
        logic [cap_depth-1:0] exp_data;
        int                   k;
        for (int i = 0; i < cap_depth; i++)
        begin
            k           = (int'(start_idx) + i) % tap_pkg::num_probes;
            exp_data[i] = word[k];
        end
        return exp_data;
    endfunction

    task automatic load_probes();
        @(posedge clk);
        probes <= {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    task automatic run_capture(input logic [tap_pkg::sel_w-1:0] cap_base, input int restart_at);
        logic [cap_depth-1:0] exp_data;
        int                   cycles;
        @(posedge clk);
        exp_data = expected_capture(probes, cap_base);
        start <= 1'b1;
        base  <= cap_base;
        cycles = 0;
        while (!done && cycles < 2 * cap_depth + 2)
        begin
            @(posedge clk);
            start <= (cycles == restart_at);
            if (cycles == restart_at)
                base <= next_index();       // must be ignored while busy.
            @(negedge clk);
            cycles++;
            if (!done)
            begin
                assert (busy)
                    else stop_on_error($sformatf("busy low before done, base %0d", cap_base));
            end
        end
        assert (done)
            else stop_on_error($sformatf("no done within %0d cycles, base %0d",
                                         2 * cap_depth + 2, cap_base));
        assert (cap_data == exp_data)
            else stop_on_error($sformatf("cap_data %h, expected %h, base %0d",
                                         cap_data, exp_data, cap_base));
        assert (!busy) else stop_on_error("busy still high with done");
        @(negedge clk);
        assert (!done) else stop_on_error("done longer than one cycle");
        if (restart_at >= 0)
        begin
            repeat (2 * cap_depth + 4)
            begin
                @(negedge clk);
                assert (!done && !busy)
                    else stop_on_error("start while busy began a second capture");
            end
            assert (cap_data == exp_data)
                else stop_on_error($sformatf("cap_data %h changed, expected %h",
                                             cap_data, exp_data));
        end
    endtask

    task automatic disarm_and_check();
        @(posedge clk);
        arm <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        assert (!triggered) else stop_on_error("triggered still high after arm dropped");
    endtask

    task automatic check_trigger_hit();
        logic [tap_pkg::sel_w-1:0] sel;
        int                        cycles;
        @(posedge clk);
        sel = next_index();
        trig_sel   <= sel;
        trig_level <= probes[sel];
        arm        <= 1'b1;
        cycles = 0;
        while (!triggered && cycles < 4)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (triggered)
            else stop_on_error($sformatf("triggered low 4 cycles after arm, sel %0d", sel));
        disarm_and_check();
    endtask

    task automatic check_trigger_miss();
        logic [tap_pkg::sel_w-1:0] sel;
        @(posedge clk);
        sel = next_index();
        trig_sel   <= sel;
        trig_level <= !probes[sel];
        arm        <= 1'b1;
        repeat (miss_cycles)
        begin
            @(negedge clk);
            assert (!triggered)
                else stop_on_error($sformatf("triggered high on a mismatch, sel %0d", sel));
        end
        disarm_and_check();
    endtask

    task automatic run_capture_with_trigger(input logic [tap_pkg::sel_w-1:0] cap_base);
        logic [tap_pkg::sel_w-1:0] sel;
        logic                      level;
        @(posedge clk);
        sel   = next_index();
        level = next_bit();
        trig_sel   <= sel;
        trig_level <= level;
        arm        <= 1'b1;
        run_capture(cap_base, -1);
        assert (triggered == (probes[sel] == level))
            else stop_on_error($sformatf("triggered %0b, expected %0b, sel %0d",
                                         triggered, probes[sel] == level, sel));
        disarm_and_check();
    endtask

    // ====================
    // test sequence
    // ====================

    initial
    begin
        seed = 32'h80d8;
        rst_n      <= 1'b0;
        probes     <= '0;
        arm        <= 1'b0;
        trig_level <= 1'b0;
        trig_sel   <= '0;
        start      <= 1'b0;
        base       <= '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!triggered && !busy && !done && cap_data == '0)
            else stop_on_error("outputs not low after reset");

        // the first two bases run past index 127.
        for (int i = 0; i < n_cap; i++)
        begin
            load_probes();
            if (i == 0)
                run_capture(tap_pkg::sel_w'(121), -1);
            else if (i == 1)
                run_capture(tap_pkg::sel_w'(127), -1);
            else
                run_capture(next_index(), -1);
        end
        for (int i = 0; i < n_hit; i++)
        begin
            load_probes();
            check_trigger_hit();
        end
        for (int i = 0; i < n_miss; i++)
        begin
            load_probes();
            check_trigger_miss();
        end
        for (int i = 0; i < n_both; i++)
        begin
            load_probes();
            run_capture_with_trigger(next_index());
        end
        for (int i = 0; i < n_restart; i++)
        begin
            load_probes();
            run_capture(next_index(), 2 + int'(next_index()) % 19);
        end

        $display("=== PASS ===");
        $finish;
    end

    initial
    begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- vlog.f
tap_pkg.sv
bit_select_tree.sv
dual_context_select.sv
tap_arbiter.sv
trigger_unit.sv
capture_unit.sv
signal_tap_top.sv
tb_clk_gen.sv
signal_tap_chk.sv
tb_signal_tap.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the signal tap testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        -f vlog.f --top-module tb_signal_tap \
        -Mdir obj_dir -o tb_signal_tap; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_signal_tap > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
